// ==== src/rs_pkg.sv ====
/*
  Shared sizes and types of the reservation station.
  ROB_LEN must be a power of two, because ROB indices wrap by truncation.
  Tag 0 means the operand is present, so ROB entry 0 is never a pending producer.
*/
`default_nettype none

package rs_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    localparam int RS_LEN    = 4;                 // station entries
    localparam int ROB_LEN   = 8;                 // rob entries, power of two
    localparam int ROB_TAG_W = $clog2(ROB_LEN);   // rob index / tag width
    localparam int XLEN      = 32;                // data word
    localparam int OP_W      = 8;                 // opaque op, carried through untouched

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // operand already present, nothing to wait for
    localparam rob_tag_t NO_TAG = '0;

    // what leaves the station on issue
    typedef struct packed {
        logic [OP_W-1:0] op;          // opaque to the station
        rob_tag_t        dest;        // rob index of this instruction
        logic [XLEN-1:0] src1_value;
        logic [XLEN-1:0] src2_value;
    } rs_payload_t;

    // op + dest + two values
    localparam int PAYLOAD_W = $bits(rs_payload_t);

endpackage

`default_nettype wire

// ==== src/rs_dispatch_if.sv ====
/*
  One dispatched instruction, shared by every station entry.
  The per-entry load strobe is not part of this bundle.
  A source tag of NO_TAG means its value field is valid.
*/
`timescale 1ns/1ps
`default_nettype none

interface rs_dispatch_if;
    import rs_pkg::*;

    logic            valid;        // dispatch strobe, used by the allocator only
    logic [OP_W-1:0] op;
    rob_tag_t        dest_tag;     // rob index given to this instruction
    rob_tag_t        src1_tag;     // producer of src1, or NO_TAG
    logic [XLEN-1:0] src1_value;
    rob_tag_t        src2_tag;     // producer of src2, or NO_TAG
    logic [XLEN-1:0] src2_value;

    // station side drives everything
    modport station (
        output valid, op, dest_tag,
        output src1_tag, src1_value,
        output src2_tag, src2_value
    );

    // entries only see the contents
    modport entry (
        input op, dest_tag,
        input src1_tag, src1_value,
        input src2_tag, src2_value
    );

endinterface

`default_nettype wire

// ==== src/rs_entry.sv ====
/*
  One reservation station slot with CDB wake-up.
  load must only hit a free slot; a load at the same edge as issue_clear wins.
  A CDB tag equal to a source tag at the load edge is captured directly (bypass).
*/
`timescale 1ns/1ps
`default_nettype none

module rs_entry (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      load,          // write this slot at the edge
    input  logic                      issue_clear,   // slot issues this cycle
    rs_dispatch_if.entry              dispatch,
    input  logic                      cdb_valid,
    input  rs_pkg::rob_tag_t          cdb_tag,
    input  logic [rs_pkg::XLEN-1:0]   cdb_value,
    output logic                      busy,
    output logic                      ready,
    output rs_pkg::rs_payload_t       payload
);
    import rs_pkg::*;

    rob_tag_t        disp_tag   [2];   // incoming source tags, index 0 = src1
    logic [XLEN-1:0] disp_value [2];
    rob_tag_t        src_tag    [2];   // NO_TAG once the value is in
    logic [XLEN-1:0] src_value  [2];
    logic [OP_W-1:0] op_q;
    rob_tag_t        dest_q;

    // broadcast matches a real pending tag
    function automatic logic cdb_hit(input rob_tag_t tag);
        return cdb_valid && (tag != NO_TAG) && (cdb_tag == tag);
    endfunction

    assign disp_tag[0]   = dispatch.src1_tag;
    assign disp_tag[1]   = dispatch.src2_tag;
    assign disp_value[0] = dispatch.src1_value;
    assign disp_value[1] = dispatch.src2_value;

    ////////////////////////////////////////
    // control state
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;                 // load wins over clear
        end else if (issue_clear) begin
            busy <= 1'b0;                 // frees itself on issue
        end
    end

    always_ff @(posedge clock) begin
        for (int s = 0; s < 2; s++) begin
            if (reset) begin
                src_tag[s] <= NO_TAG;
            end else if (load) begin
                src_tag[s] <= cdb_hit(disp_tag[s]) ? NO_TAG : disp_tag[s];  // bypass
            end else if (busy && cdb_hit(src_tag[s])) begin
                src_tag[s] <= NO_TAG;     // wake-up
            end
        end
    end

    ////////////////////////////////////////
    // payload
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (load) begin
            op_q   <= dispatch.op;
            dest_q <= dispatch.dest_tag;
        end
        for (int s = 0; s < 2; s++) begin
            if (load) begin
                src_value[s] <= cdb_hit(disp_tag[s]) ? cdb_value : disp_value[s];
            end else if (busy && cdb_hit(src_tag[s])) begin
                src_value[s] <= cdb_value;    // value from the producer
            end
        end
    end

    assign ready = busy && (src_tag[0] == NO_TAG) && (src_tag[1] == NO_TAG);

    assign payload.op         = op_q;
    assign payload.dest       = dest_q;
    assign payload.src1_value = src_value[0];
    assign payload.src2_value = src_value[1];

    // allocator only ever picks a free slot
    a_load_free : assert property (@(posedge clock) disable iff (reset) load |-> !busy)
        else $error("rs_entry: load while busy");

    // issue selection only clears what it may issue
    a_clear_ready : assert property (@(posedge clock) disable iff (reset)
        issue_clear |-> ready)
        else $error("rs_entry: issue_clear on a slot that is not ready");

endmodule

`default_nettype wire

// ==== src/rob_age_select.sv ====
/*
  Oldest-first pick over ROB indices, counted upward from the head with wrap.
  Purely combinational. ROB_LEN must be a power of two.
*/
`timescale 1ns/1ps
`default_nettype none

module rob_age_select (
    input  logic [rs_pkg::ROB_LEN-1:0] request,   // one bit per rob index
    input  rs_pkg::rob_tag_t           head,      // oldest rob index
    output logic [rs_pkg::ROB_LEN-1:0] grant,     // one-hot or zero
    output logic                       any
);
    import rs_pkg::*;

    logic [2*ROB_LEN-1:0] req_twice;     // request doubled, shifted down by head
    logic [ROB_LEN-1:0]   req_rot;       // bit k is rob index head + k
    logic [ROB_LEN-1:0]   first_rot;     // lowest set bit of req_rot
    logic [2*ROB_LEN-1:0] grant_twice;   // first_rot doubled, shifted back up

    ////////////////////////////////////////
    // rotating search
    ////////////////////////////////////////

    // head lands on bit 0
    assign req_twice = {request, request} >> head;
    assign req_rot   = req_twice[ROB_LEN-1:0];

    // x & -x keeps only the lowest set bit
    // lowest bit after the rotate is the index nearest the head
    assign first_rot = req_rot & (-req_rot);

    // back to rob index order
    assign grant_twice = {first_rot, first_rot} << head;
    assign grant       = grant_twice[2*ROB_LEN-1:ROB_LEN];

    assign any = |request;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // rerun whenever grant settles
    always_comb begin
        a_grant_onehot : assert ($onehot0(grant))
            else $error("rob_age_select: grant not one-hot");
        a_grant_any : assert (any == (grant != '0))
            else $error("rob_age_select: grant and any disagree");
    end

endmodule

`default_nettype wire

// ==== src/reservation_station.sv ====
/*
  Reservation station top: first-free allocation, CDB wake-up, oldest-first issue.
  A dispatch while dispatch_stall is high is dropped, there is no queue.
  Issue has no back-pressure; the issued slot is free after the next edge.
  Busy entries must hold distinct destination ROB indices.
*/
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      dispatch_valid,
    input  logic [rs_pkg::OP_W-1:0]   dispatch_op,
    input  rs_pkg::rob_tag_t          dispatch_dest,
    input  rs_pkg::rob_tag_t          dispatch_src1_tag,
    input  logic [rs_pkg::XLEN-1:0]   dispatch_src1_value,
    input  rs_pkg::rob_tag_t          dispatch_src2_tag,
    input  logic [rs_pkg::XLEN-1:0]   dispatch_src2_value,
    input  logic                      cdb_valid,
    input  rs_pkg::rob_tag_t          cdb_tag,
    input  logic [rs_pkg::XLEN-1:0]   cdb_value,
    input  rs_pkg::rob_tag_t          rob_head,
    output logic                      dispatch_stall,
    output logic                      issue_valid,
    output logic [rs_pkg::OP_W-1:0]   issue_op,
    output rs_pkg::rob_tag_t          issue_dest,
    output logic [rs_pkg::XLEN-1:0]   issue_src1_value,
    output logic [rs_pkg::XLEN-1:0]   issue_src2_value
);
    import rs_pkg::*;

    rs_dispatch_if dispatch ();

    logic [RS_LEN-1:0]  entry_load;      // one-hot or zero
    logic [RS_LEN-1:0]  entry_busy;
    logic [RS_LEN-1:0]  entry_ready;
    logic [RS_LEN-1:0]  entry_clear;     // slot being issued
    rs_payload_t        entry_payload [RS_LEN];
    logic [ROB_LEN-1:0] issue_request;   // ready entries, by dest rob index
    logic [ROB_LEN-1:0] issue_grant;
    rs_payload_t        issue_payload;

    assign dispatch.valid      = dispatch_valid;
    assign dispatch.op         = dispatch_op;
    assign dispatch.dest_tag   = dispatch_dest;
    assign dispatch.src1_tag   = dispatch_src1_tag;
    assign dispatch.src1_value = dispatch_src1_value;
    assign dispatch.src2_tag   = dispatch_src2_tag;
    assign dispatch.src2_value = dispatch_src2_value;

    ////////////////////////////////////////
    // allocation
    ////////////////////////////////////////

    // lowest free slot wins, scan from the top
    always_comb begin
        entry_load = '0;
        for (int i = RS_LEN - 1; i >= 0; i--) begin
            if (!entry_busy[i]) begin
                entry_load    = '0;
                entry_load[i] = dispatch.valid;
            end
        end
    end

    assign dispatch_stall = &entry_busy;   // all full, dispatch dropped

    for (genvar i = 0; i < RS_LEN; i++) begin : g_entry
        rs_entry u_entry (
            .clock       (clock),
            .reset       (reset),
            .load        (entry_load[i]),
            .issue_clear (entry_clear[i]),
            .dispatch    (dispatch.entry),
            .cdb_valid   (cdb_valid),
            .cdb_tag     (cdb_tag),
            .cdb_value   (cdb_value),
            .busy        (entry_busy[i]),
            .ready       (entry_ready[i]),
            .payload     (entry_payload[i])
        );
    end

    ////////////////////////////////////////
    // issue
    ////////////////////////////////////////

    always_comb begin
        issue_request = '0;
        for (int i = 0; i < RS_LEN; i++) begin
            if (entry_ready[i]) begin
                issue_request[entry_payload[i].dest] = 1'b1;
            end
        end
    end

    rob_age_select u_age_select (
        .request (issue_request),
        .head    (rob_head),
        .grant   (issue_grant),
        .any     (issue_valid)
    );

    // dests are unique, so at most one slot matches the grant
    always_comb begin
        issue_payload = '0;
        entry_clear   = '0;
        for (int i = 0; i < RS_LEN; i++) begin
            if (entry_ready[i] && issue_grant[entry_payload[i].dest]) begin
                issue_payload  = entry_payload[i];
                entry_clear[i] = 1'b1;
            end
        end
    end

    assign issue_op         = issue_payload.op;
    assign issue_dest       = issue_payload.dest;
    assign issue_src1_value = issue_payload.src1_value;
    assign issue_src2_value = issue_payload.src2_value;

    // the rob hands out each index once, otherwise issue would be ambiguous
    for (genvar i = 0; i < RS_LEN; i++) begin : g_dest_chk
        for (genvar j = i + 1; j < RS_LEN; j++) begin : g_pair
            a_dest_unique : assert property (@(posedge clock) disable iff (reset)
                !(entry_busy[i] && entry_busy[j]
                  && (entry_payload[i].dest == entry_payload[j].dest)))
                else $error("reservation_station: entries %0d and %0d share a dest", i, j);
        end
    end

endmodule

`default_nettype wire

// ==== dv/rs_checker.sv ====
/*
  Compares the reservation station outputs with the expected data columns.
  Samples at the rising edge, before the DUT state moves on.
  Issue fields count only when issue_valid is expected high.
*/
`timescale 1ns/1ps
`default_nettype none

module rs_checker (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    check_enable,    // a data line is applied
    input  logic                    exp_stall,
    input  logic                    exp_valid,
    input  rs_pkg::rs_payload_t     exp_issue,
    input  logic                    dispatch_stall,
    input  logic                    issue_valid,
    input  logic [rs_pkg::OP_W-1:0] issue_op,
    input  rs_pkg::rob_tag_t        issue_dest,
    input  logic [rs_pkg::XLEN-1:0] issue_src1_value,
    input  logic [rs_pkg::XLEN-1:0] issue_src2_value,
    output int                      error_count
);
    import rs_pkg::*;

    int errors = 0;

    // x or z on the DUT side also counts as wrong
    task automatic compare_value(input string name,
                                 input logic [XLEN-1:0] expected,
                                 input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // per-cycle compare
    ////////////////////////////////////////

    always @(posedge clock) begin
        if (!reset && check_enable) begin
            compare_value("dispatch_stall", XLEN'(exp_stall), XLEN'(dispatch_stall));
            compare_value("issue_valid", XLEN'(exp_valid), XLEN'(issue_valid));
            if (exp_valid) begin
                compare_value("issue_op", XLEN'(exp_issue.op), XLEN'(issue_op));
                compare_value("issue_dest", XLEN'(exp_issue.dest), XLEN'(issue_dest));
                compare_value("issue_src1_value", exp_issue.src1_value, issue_src1_value);
                compare_value("issue_src2_value", exp_issue.src2_value, issue_src2_value);
            end
        end
    end

    assign error_count = errors;   // read by the top at the end

endmodule

`default_nettype wire

// ==== dv/reservation_station_tb.sv ====
/*
  Reservation station testbench, one line of dv/rs_testdata.txt per cycle.
  Run from the project root so that the data file path resolves.
  Expected columns are the outputs while that line's inputs are applied.
*/
`timescale 1ns/1ps
`default_nettype none

module reservation_station_tb;
    import rs_pkg::*;

    localparam int    COLS          = 17;      // columns per data line
    localparam int    RESET_CYCLES  = 2;
    localparam int    TIMEOUT_SLACK = 20;      // cycles on top of the data lines
    localparam string DATA_FILE     = "dv/rs_testdata.txt";

    typedef struct packed {
        logic            disp_valid;
        rs_payload_t     disp;        // op, dest and both source values
        rob_tag_t        src1_tag;
        rob_tag_t        src2_tag;
        logic            cdb_valid;
        rob_tag_t        cdb_tag;
        logic [XLEN-1:0] cdb_value;
        rob_tag_t        rob_head;
        logic            exp_stall;
        logic            exp_valid;
        rs_payload_t     exp_issue;
    } cycle_vec_t;

    logic clock;
    logic reset;
    logic dispatch_valid, cdb_valid, dispatch_stall, issue_valid;
    logic [OP_W-1:0] dispatch_op, issue_op;
    rob_tag_t dispatch_dest, dispatch_src1_tag, dispatch_src2_tag;
    rob_tag_t cdb_tag, rob_head, issue_dest;
    logic [XLEN-1:0] dispatch_src1_value, dispatch_src2_value, cdb_value;
    logic [XLEN-1:0] issue_src1_value, issue_src2_value;
    logic check_enable, exp_stall, exp_valid;
    rs_payload_t exp_issue;
    int mismatch_count;
    int other_errors  = 0;
    int cycle_count   = 0;
    int timeout_limit = TIMEOUT_SLACK;   // raised once the data is read
    cycle_vec_t vectors [$];

    always #20 clock = ~clock;   // 40 ns period

    reservation_station DUT (.*);

    rs_checker u_checker (
        .clock (clock), .reset (reset), .check_enable (check_enable),
        .exp_stall (exp_stall), .exp_valid (exp_valid), .exp_issue (exp_issue),
        .dispatch_stall (dispatch_stall), .issue_valid (issue_valid),
        .issue_op (issue_op), .issue_dest (issue_dest),
        .issue_src1_value (issue_src1_value), .issue_src2_value (issue_src2_value),
        .error_count (mismatch_count)
    );

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    task automatic drive_cycle(input cycle_vec_t v);
        dispatch_valid      = v.disp_valid;
        dispatch_op         = v.disp.op;
        dispatch_dest       = v.disp.dest;
        dispatch_src1_tag   = v.src1_tag;
        dispatch_src1_value = v.disp.src1_value;
        dispatch_src2_tag   = v.src2_tag;
        dispatch_src2_value = v.disp.src2_value;
        cdb_valid           = v.cdb_valid;
        cdb_tag             = v.cdb_tag;
        cdb_value           = v.cdb_value;
        rob_head            = v.rob_head;
        exp_stall           = v.exp_stall;    // checker side
        exp_valid           = v.exp_valid;
        exp_issue           = v.exp_issue;
    endtask

    // comment and blank lines parse to nothing and are skipped
    task automatic load_vectors();
        int              fd;
        int              n;
        int              line_no;
        string           line;
        logic [XLEN-1:0] col [COLS];
        cycle_vec_t      v;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open the data file %s", DATA_FILE);
            other_errors++;
            return;
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                col[9], col[10], col[11], col[12], col[13], col[14], col[15], col[16]);
            if (n == COLS) begin
                v.disp_valid      = col[0][0];
                v.disp.op         = OP_W'(col[1]);
                v.disp.dest       = rob_tag_t'(col[2]);
                v.src1_tag        = rob_tag_t'(col[3]);
                v.disp.src1_value = col[4];
                v.src2_tag        = rob_tag_t'(col[5]);
                v.disp.src2_value = col[6];
                v.cdb_valid       = col[7][0];
                v.cdb_tag         = rob_tag_t'(col[8]);
                v.cdb_value       = col[9];
                v.rob_head        = rob_tag_t'(col[10]);
                v.exp_stall       = col[11][0];
                v.exp_valid       = col[12][0];
                v.exp_issue       = {OP_W'(col[13]), rob_tag_t'(col[14]), col[15], col[16]};
                vectors.push_back(v);
            end else if (n > 0) begin
                $display("data line %0d has %0d columns instead of %0d", line_no, n, COLS);
                other_errors++;
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        check_enable = 1'b0;
        drive_cycle('0);               // all inputs low
        load_vectors();
        if (vectors.size() == 0) begin
            $display("no test vectors were read, nothing to run");
            other_errors++;
        end
        timeout_limit = vectors.size() + TIMEOUT_SLACK;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        foreach (vectors[i]) begin
            drive_cycle(vectors[i]);   // falling edge drive
            check_enable = 1'b1;
            @(negedge clock);          // checker sampled at the rising edge between
        end
        check_enable = 1'b0;
        drive_cycle('0);
        $display("errors: %0d value mismatches, %0d other failures",
            mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog, limit follows the number of data lines
    initial begin
        while (cycle_count < timeout_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the data lines never finished", cycle_count);
        $display("errors: %0d value mismatches, %0d other failures",
            mismatch_count, other_errors + 1);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/rs_testdata.txt ====
# inputs: dispatch_valid op dest src1_tag src1_value src2_tag src2_value cdb_valid cdb_tag cdb_value rob_head
# expected: dispatch_stall issue_valid issue_op issue_dest issue_src1_value issue_src2_value (hex)
# idle after reset
0 00 0 0 00000000 0 00000000 0 0 00000000 0  0 0 00 0 00000000 00000000
0 00 0 0 00000000 0 00000000 0 0 00000000 0  0 0 00 0 00000000 00000000
# both operands present
1 11 1 0 00000011 0 00000022 0 0 00000000 1  0 0 00 0 00000000 00000000
0 00 0 0 00000000 0 00000000 0 0 00000000 1  0 1 11 1 00000011 00000022
0 00 0 0 00000000 0 00000000 0 0 00000000 1  0 0 00 0 00000000 00000000
# wake-up from the cdb
1 21 2 5 00000000 0 00000b0b 0 0 00000000 2  0 0 00 0 00000000 00000000
0 00 0 0 00000000 0 00000000 0 0 00000000 2  0 0 00 0 00000000 00000000
0 00 0 0 00000000 0 00000000 1 5 55550005 2  0 0 00 0 00000000 00000000
0 00 0 0 00000000 0 00000000 0 0 00000000 2  0 1 21 2 55550005 00000b0b
# bypass in the dispatch cycle
1 31 3 6 00000000 7 00000000 1 6 66660006 3  0 0 00 0 00000000 00000000
0 00 0 0 00000000 0 00000000 1 7 77770007 3  0 0 00 0 00000000 00000000
0 00 0 0 00000000 0 00000000 0 0 00000000 3  0 1 31 3 66660006 77770007
1 32 4 6 00000000 6 00000000 1 6 0000abcd 4  0 0 00 0 00000000 00000000
0 00 0 0 00000000 0 00000000 0 0 00000000 4  0 1 32 4 0000abcd 0000abcd
# age order from rob_head 5 with wrap
1 41 7 2 00000000 0 00000007 0 0 00000000 5  0 0 00 0 00000000 00000000
1 42 1 2 00000000 0 00000001 0 0 00000000 5  0 0 00 0 00000000 00000000
1 43 5 0 00000005 2 00000000 0 0 00000000 5  0 0 00 0 00000000 00000000
0 00 0 0 00000000 0 00000000 1 2 22220002 5  0 0 00 0 00000000 00000000
0 00 0 0 00000000 0 00000000 0 0 00000000 5  0 1 43 5 00000005 22220002
0 00 0 0 00000000 0 00000000 0 0 00000000 5  0 1 41 7 22220002 00000007
0 00 0 0 00000000 0 00000000 0 0 00000000 5  0 1 42 1 22220002 00000001
0 00 0 0 00000000 0 00000000 0 0 00000000 5  0 0 00 0 00000000 00000000
# full station, dropped dispatch, then reuse
1 51 1 3 00000000 0 00000100 0 0 00000000 1  0 0 00 0 00000000 00000000
1 52 2 3 00000000 0 00000200 0 0 00000000 1  0 0 00 0 00000000 00000000
1 53 4 6 00000000 0 00000400 0 0 00000000 1  0 0 00 0 00000000 00000000
1 54 5 6 00000000 0 00000500 0 0 00000000 1  0 0 00 0 00000000 00000000
1 5f 6 0 dead0006 0 00000000 0 0 00000000 1  1 0 00 0 00000000 00000000
0 00 0 0 00000000 0 00000000 1 3 33330003 1  1 0 00 0 00000000 00000000
0 00 0 0 00000000 0 00000000 0 0 00000000 1  1 1 51 1 33330003 00000100
1 55 7 0 00000777 0 00000077 0 0 00000000 1  0 1 52 2 33330003 00000200
0 00 0 0 00000000 0 00000000 1 6 66660066 1  0 1 55 7 00000777 00000077
0 00 0 0 00000000 0 00000000 0 0 00000000 1  0 1 53 4 66660066 00000400
0 00 0 0 00000000 0 00000000 0 0 00000000 1  0 1 54 5 66660066 00000500
0 00 0 0 00000000 0 00000000 0 0 00000000 1  0 0 00 0 00000000 00000000
0 00 0 0 00000000 0 00000000 0 0 00000000 1  0 0 00 0 00000000 00000000

// ==== reservation_station.f ====
src/rs_pkg.sv
src/rs_dispatch_if.sv
src/rs_entry.sv
src/rob_age_select.sv
src/reservation_station.sv
dv/rs_checker.sv
dv/reservation_station_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the reservation station testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f reservation_station.f \
    --top-module reservation_station_tb \
    -o rs_sim

output=$(./obj_dir/rs_sim)
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
